/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
        --top-module tb_hub75 -f tb.f --Mdir "$BUILD_DIR" -o sim_hub75 > "$BUILD_LOG" 2>&1; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/sim_hub75" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$SIM_LOG"; then
    exit 1
fi
exit 0

/* tb.f */
verilog/hub75_pkg.sv
verilog/pixel_fetch_if.sv
verilog/uart_rx.sv
verilog/command_decoder.sv
verilog/framebuffer_ram.sv
verilog/pixel_fetch.sv
verilog/matrix_scan.sv
verilog/hub75_top.sv
testbench/tb_clock.sv
testbench/scan_checker.sv
testbench/tb_hub75.sv

/* testbench/hub75_patterns.txt */
# F fill | P row col pixel | B plane_mask | E color_mask | C check_name
# row and col decimal, pixel and masks hex, color mask bit 0 red, 1 green, 2 blue
F
C random_fill
P 2 5 f81f
P 6 9 07e0
P 7 15 a5c3
C single_pixel
B 15
C brightness_mask
B 1f
E 2
C color_green
E 5
C color_red_blue
E 7
C all_enabled

/* testbench/scan_checker.sv */
`timescale 1ns/10ps
module scan_checker #(
    parameter int PIXEL_WIDTH       = hub75_pkg::PIXEL_WIDTH,
    parameter int PIXEL_HEIGHT      = hub75_pkg::PIXEL_HEIGHT,
    parameter int BRIGHTNESS_LEVELS = hub75_pkg::BRIGHTNESS_LEVELS,
    parameter int OE_BASE_CYCLES    = hub75_pkg::OE_BASE_CYCLES,
    localparam int HALF  = PIXEL_HEIGHT / 2,
    localparam int ROW_W = $clog2(HALF)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  hub75_pkg::rgb_t  rgb_top,
    input  hub75_pkg::rgb_t  rgb_bottom,
    input  logic             clk_pixel,
    input  logic             row_latch,
    input  logic             output_enable,
    input  logic [ROW_W-1:0] row_addr,
    output logic             check_done,
    output int               error_count
);
    localparam int FRAME_PIXELS = HALF * BRIGHTNESS_LEVELS * PIXEL_WIDTH;

    // expected image and masks, written by the testbench top
    hub75_pkg::pixel_t            image [PIXEL_HEIGHT][PIXEL_WIDTH];
    logic [BRIGHTNESS_LEVELS-1:0] plane_mask = '1;
    hub75_pkg::rgb_t              color_mask = '1;

    string check_name = "none";
    int    start_seq = 0;   // bumped per requested check
    int    armed_seq = 0;
    int    done_seq = 0;
    int    frames_left = 0;
    bit    checking = 1'b0;
    int    compares = 0;

    int   pix_count = 0;    // pixel clocks since the last latch
    int   oe_count = 0;
    int   exp_plane = 0;
    int   exp_row = 0;
    int   latched_plane = 0;
    logic clk_pixel_q = 1'b0;
    logic oe_q = 1'b0;

    initial error_count = 0;

    assign check_done = done_seq == start_seq;

    task automatic set_pixel(input int row, input int col, input hub75_pkg::pixel_t value);
        if (row < PIXEL_HEIGHT && col < PIXEL_WIDTH) image[row][col] = value;
    endtask

    task automatic set_brightness(input logic [7:0] mask);
        plane_mask = mask[BRIGHTNESS_LEVELS-1:0];
    endtask

    task automatic set_color(input logic [7:0] mask);
        color_mask = mask[2:0];
    endtask

    task automatic start_check(input string name);
        check_name = name;
        start_seq++;
    endtask

    // rgb565 fields, plane p takes red bit p, green bit p+1, blue bit p
    function automatic hub75_pkg::rgb_t expected_bits(input hub75_pkg::pixel_t px,
                                                      input int plane);
        logic [4:0]      red;
        logic [5:0]      green;
        logic [4:0]      blue;
        logic [2:0]      p;
        hub75_pkg::rgb_t bits;
        red   = px[15:11];
        green = px[10:5];
        blue  = px[4:0];
        p     = 3'(plane);
        bits  = {blue[p], green[3'(plane + 1)], red[p]};
        if (!plane_mask[p]) bits = '0;
        return bits & color_mask;
    endfunction

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("Error: %s expected %0h actual %0h", name, expected, actual);
        error_count++;
    endtask

    task automatic compare_pixel();
        hub75_pkg::rgb_t exp_top;
        hub75_pkg::rgb_t exp_bottom;
        string           where;
        exp_top    = expected_bits(image[exp_row][pix_count], exp_plane);
        exp_bottom = expected_bits(image[exp_row + HALF][pix_count], exp_plane);
        where      = $sformatf("%s row %0d plane %0d col %0d", check_name, exp_row,
                               exp_plane, pix_count);
        compares++;
        if (rgb_top !== exp_top) report_value({where, " top"}, 32'(exp_top), 32'(rgb_top));
        if (rgb_bottom !== exp_bottom)
            report_value({where, " bottom"}, 32'(exp_bottom), 32'(rgb_bottom));
    endtask

    task automatic end_of_frame();
        if (checking) begin
            checking = 1'b0;
            if (compares != FRAME_PIXELS) begin
                $display("check %s saw %0d pixels in its frame instead of %0d",
                         check_name, compares, FRAME_PIXELS);
                error_count++;
            end
            done_seq = armed_seq;
        end else if (armed_seq != done_seq) begin
            frames_left--;
            if (frames_left == 0) begin
                checking = 1'b1;
                compares = 0;
            end
        end
    endtask

    task automatic next_plane();
        if (exp_plane == BRIGHTNESS_LEVELS - 1) begin
            exp_plane = 0;
            if (exp_row == HALF - 1) begin
                exp_row = 0;
                end_of_frame();
            end else begin
                exp_row++;
            end
        end else begin
            exp_plane++;
        end
    endtask

    // sampled mid cycle, away from the DUT's clock edge
    always @(negedge clk) begin
        if (!rst_n) begin
            if (clk_pixel !== 1'b0) report_value("reset clk_pixel", 0, 32'(clk_pixel));
            if (row_latch !== 1'b0) report_value("reset row_latch", 0, 32'(row_latch));
            if (output_enable !== 1'b0)
                report_value("reset output_enable", 0, 32'(output_enable));
            if (row_addr !== '0) report_value("reset row_addr", 0, 32'(row_addr));
            pix_count   = 0;
            exp_plane   = 0;
            exp_row     = 0;
            clk_pixel_q = 1'b0;
            oe_q        = 1'b0;
        end else begin
            if (start_seq != armed_seq) begin
                armed_seq   = start_seq;
                frames_left = 3;    // first frame end may close a partial frame
                checking    = 1'b0;
            end
            if (clk_pixel && !clk_pixel_q) begin
                if (pix_count >= PIXEL_WIDTH) begin
                    $display("more than %0d pixel clocks before a latch", PIXEL_WIDTH);
                    error_count++;
                end else if (checking) begin
                    compare_pixel();
                end
                pix_count++;
            end
            if (row_latch) begin
                if (pix_count != PIXEL_WIDTH) report_value("pixel_count", PIXEL_WIDTH, pix_count);
                if (int'(row_addr) != exp_row) report_value("row_addr", exp_row, 32'(row_addr));
                latched_plane = exp_plane;
                oe_count      = 0;
                pix_count     = 0;
            end
            if (output_enable) oe_count++;
            if (oe_q && !output_enable) begin
                if (oe_count != (OE_BASE_CYCLES << latched_plane))
                    report_value("oe_length", OE_BASE_CYCLES << latched_plane, oe_count);
                next_plane();
            end
            clk_pixel_q = clk_pixel;
            oe_q        = output_enable;
        end
    end

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/10ps
module tb_clock (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end
endmodule

/* testbench/tb_hub75.sv */
`timescale 1ns/10ps
module tb_hub75;
    localparam int WIDTH  = hub75_pkg::PIXEL_WIDTH;
    localparam int HEIGHT = hub75_pkg::PIXEL_HEIGHT;
    localparam int LEVELS = hub75_pkg::BRIGHTNESS_LEVELS;
    localparam int TICKS  = hub75_pkg::CTRL_TICKS_PER_BIT;
    localparam int ROW_W  = $clog2(hub75_pkg::PIXEL_HALFHEIGHT);
    // shifting plus latch per plane, then all enable times, for every scan row
    localparam int FRAME_CYCLES = hub75_pkg::PIXEL_HALFHEIGHT *
        (LEVELS * (WIDTH * 4 + 1) + hub75_pkg::OE_BASE_CYCLES * ((1 << LEVELS) - 1));
    localparam int CHECK_TIMEOUT = 6 * FRAME_CYCLES;

    logic             clk;
    logic             rst_n;
    logic             uart_rx_line;
    hub75_pkg::rgb_t  rgb_top;
    hub75_pkg::rgb_t  rgb_bottom;
    logic             clk_pixel;
    logic             row_latch;
    logic             output_enable;
    logic [ROW_W-1:0] row_addr;
    logic             check_done;
    int               compare_errors;
    int               timeout_errors = 0;
    int               pattern_errors = 0;
    logic [31:0]      lfsr = 32'h9f1d_70b0;

    tb_clock clock_gen (.clk(clk));

    hub75_top #(
        .PIXEL_WIDTH(WIDTH),
        .PIXEL_HEIGHT(HEIGHT),
        .BRIGHTNESS_LEVELS(LEVELS),
        .TICKS_PER_BIT(TICKS),
        .OE_BASE_CYCLES(hub75_pkg::OE_BASE_CYCLES)
    ) hub75_top_inst (
        .clk(clk),
        .rst_n(rst_n),
        .uart_rx_line(uart_rx_line),
        .rgb_top(rgb_top),
        .rgb_bottom(rgb_bottom),
        .clk_pixel(clk_pixel),
        .row_latch(row_latch),
        .output_enable(output_enable),
        .row_addr(row_addr)
    );

    scan_checker #(
        .PIXEL_WIDTH(WIDTH),
        .PIXEL_HEIGHT(HEIGHT),
        .BRIGHTNESS_LEVELS(LEVELS),
        .OE_BASE_CYCLES(hub75_pkg::OE_BASE_CYCLES)
    ) checker_inst (
        .clk(clk),
        .rst_n(rst_n),
        .rgb_top(rgb_top),
        .rgb_bottom(rgb_bottom),
        .clk_pixel(clk_pixel),
        .row_latch(row_latch),
        .output_enable(output_enable),
        .row_addr(row_addr),
        .check_done(check_done),
        .error_count(compare_errors)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // 8N1, lsb first
    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            for (int t = 0; t < TICKS; t++) begin
                @(posedge clk);
                uart_rx_line <= frame[i];
            end
        end
    endtask

    task automatic send_pixel(input int row, input int col, input hub75_pkg::pixel_t px);
        send_byte(hub75_pkg::CMD_SET_PIXEL);
        send_byte(8'(row));
        send_byte(8'(col));
        send_byte(px[15:8]);
        send_byte(px[7:0]);
        checker_inst.set_pixel(row, col, px);
    endtask

    task automatic fill_random();
        hub75_pkg::pixel_t px;
        px = '0;
        for (int r = 0; r < HEIGHT; r++) begin
            for (int c = 0; c < WIDTH; c++) begin
                for (int b = 0; b < 16; b++) begin
                    lfsr = lfsr_step(lfsr);
                    px   = {px[14:0], lfsr[0]};
                end
                send_pixel(r, c, px);
            end
        end
    endtask

    task automatic run_check(input string name, output bit ok);
        int waited;
        waited = 0;
        @(posedge clk);
        checker_inst.start_check(name);
        @(posedge clk);
        while (!check_done && waited < CHECK_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        ok = check_done;
        if (ok) $display("check %s finished", name);
        else $display("timeout: check %s did not finish in %0d cycles", name, CHECK_TIMEOUT);
    endtask

    initial begin
        int          fd;
        int          n;
        int          code;
        int          row;
        int          col;
        logic [31:0] value;
        logic [7:0]  cmd;
        string       line;
        string       args;
        bit          ok;
        bit          running;
        rst_n        = 1'b0;
        uart_rx_line = 1'b1;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        fd = $fopen("testbench/hub75_patterns.txt", "r");
        running = fd != 0;
        if (fd == 0) begin
            $display("could not open testbench/hub75_patterns.txt");
            pattern_errors++;
        end
        while (running) begin
            line = "";
            code = $fgets(line, fd);
            if (code == 0) begin
                running = 1'b0;
            end else begin
                n = line.len();
                while (n > 0 && (line.getc(n - 1) == 8'h0a || line.getc(n - 1) == 8'h0d ||
                                 line.getc(n - 1) == " ")) n--;
                cmd  = (n > 0) ? line.getc(0) : "#";
                args = (n > 2) ? line.substr(2, n - 1) : "";
                case (cmd)
                    "#": ;  // comment or blank
                    "F": fill_random();
                    "P": begin
                        code = $sscanf(args, "%d %d %h", row, col, value);
                        if (code == 3) send_pixel(row, col, value[15:0]);
                        else pattern_errors++;
                    end
                    "B": begin
                        code = $sscanf(args, "%h", value);
                        if (code == 1) begin
                            send_byte(hub75_pkg::CMD_BRIGHTNESS);
                            send_byte(value[7:0]);
                            checker_inst.set_brightness(value[7:0]);
                        end else begin
                            pattern_errors++;
                        end
                    end
                    "E": begin
                        code = $sscanf(args, "%h", value);
                        if (code == 1) begin
                            send_byte(hub75_pkg::CMD_RGB_ENABLE);
                            send_byte(value[7:0]);
                            checker_inst.set_color(value[7:0]);
                        end else begin
                            pattern_errors++;
                        end
                    end
                    "C": begin
                        run_check(args, ok);
                        if (!ok) begin
                            timeout_errors++;
                            running = 1'b0;
                        end
                    end
                    default: begin
                        $display("unknown pattern line: %s", line);
                        pattern_errors++;
                    end
                endcase
            end
        end
        if (fd != 0) $fclose(fd);
        $display("compare errors: %0d, timeouts: %0d, pattern errors: %0d",
                 compare_errors, timeout_errors, pattern_errors);
        if (compare_errors == 0 && timeout_errors == 0 && pattern_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verilog/command_decoder.sv */
`timescale 1ns/10ps
module command_decoder #(
    parameter int PIXEL_WIDTH       = hub75_pkg::PIXEL_WIDTH,
    parameter int PIXEL_HEIGHT      = hub75_pkg::PIXEL_HEIGHT,
    parameter int BRIGHTNESS_LEVELS = hub75_pkg::BRIGHTNESS_LEVELS,
    localparam int ADDR_W = $clog2(PIXEL_WIDTH * PIXEL_HEIGHT / 2) + 2
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [7:0]                   rx_data,
    input  logic                         rx_valid,
    output logic                         wr_en,
    output logic [ADDR_W-1:0]            wr_addr,
    output logic [7:0]                   wr_data,
    output logic [BRIGHTNESS_LEVELS-1:0] brightness_enable,
    output hub75_pkg::rgb_t              rgb_enable
);
    localparam int HALF  = PIXEL_HEIGHT / 2;
    localparam int ROW_W = $clog2(PIXEL_HEIGHT);

    typedef enum logic [2:0] {IDLE, ROW, COL, DATA_HI, DATA_LO, BRIGHT, COLOR} state_t;

    state_t            state;
    logic [ROW_W-1:0]  row_q;
    logic              row_ok;
    logic              pix_ok;      // row and column both on the panel
    logic [ADDR_W-2:0] pix_addr;    // word index and half select
    logic              half;
    logic [ROW_W-1:0]  srow;
    logic [ADDR_W-3:0] word_idx;

    // bottom half rows share the word of the matching top row
    assign half     = row_q >= ROW_W'(HALF);
    assign srow     = half ? row_q - ROW_W'(HALF) : row_q;
    assign word_idx = (ADDR_W - 2)'(srow * PIXEL_WIDTH + rx_data);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state             <= IDLE;
            wr_en             <= 1'b0;
            row_ok            <= 1'b0;
            pix_ok            <= 1'b0;
            brightness_enable <= '1;
            rgb_enable        <= '1;
        end else begin
            wr_en <= 1'b0;
            if (rx_valid) begin
                case (state)
                    IDLE: begin
                        case (rx_data)
                            hub75_pkg::CMD_SET_PIXEL:  state <= ROW;
                            hub75_pkg::CMD_BRIGHTNESS: state <= BRIGHT;
                            hub75_pkg::CMD_RGB_ENABLE: state <= COLOR;
                            default:                   state <= IDLE;
                        endcase
                    end
                    ROW: begin
                        row_ok <= rx_data < PIXEL_HEIGHT;
                        state  <= COL;
                    end
                    COL: begin
                        pix_ok <= row_ok && rx_data < PIXEL_WIDTH;
                        state  <= DATA_HI;
                    end
                    DATA_HI: begin
                        wr_en <= pix_ok;    // bad address still eats the data bytes
                        state <= DATA_LO;
                    end
                    DATA_LO: begin
                        wr_en <= pix_ok;
                        state <= IDLE;
                    end
                    BRIGHT: begin
                        brightness_enable <= rx_data[BRIGHTNESS_LEVELS-1:0];
                        state             <= IDLE;
                    end
                    default: begin
                        rgb_enable <= rx_data[2:0];
                        state      <= IDLE;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid) begin
            if (state == ROW) row_q <= rx_data[ROW_W-1:0];
            if (state == COL) pix_addr <= {word_idx, half};
            if (state == DATA_HI || state == DATA_LO) begin
                wr_addr <= {pix_addr, state == DATA_LO};   // high byte first
                wr_data <= rx_data;
            end
        end
    end

    a_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> int'(wr_addr) < PIXEL_WIDTH * PIXEL_HEIGHT * 2);

endmodule

/* verilog/framebuffer_ram.sv */
`timescale 1ns/10ps
module framebuffer_ram #(
    parameter int PIXEL_WIDTH  = hub75_pkg::PIXEL_WIDTH,
    parameter int PIXEL_HEIGHT = hub75_pkg::PIXEL_HEIGHT,
    localparam int WORD_W = $clog2(PIXEL_WIDTH * PIXEL_HEIGHT / 2),
    localparam int ADDR_W = WORD_W + 2
) (
    input  logic                    clk,
    input  logic                    wr_en,
    input  logic [ADDR_W-1:0]       wr_addr,
    input  logic [7:0]              wr_data,
    input  logic [WORD_W-1:0]       rd_addr,
    output hub75_pkg::pixel_t [1:0] rd_data     // [0] top, [1] bottom
);
    localparam int WORDS = PIXEL_WIDTH * PIXEL_HEIGHT / 2;

    // byte 0 top high, 1 top low, 2 bottom high, 3 bottom low
    logic [3:0][7:0] mem [WORDS];

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_addr[ADDR_W-1:2]][wr_addr[1:0]] <= wr_data;
        rd_data <= {mem[rd_addr][2], mem[rd_addr][3], mem[rd_addr][0], mem[rd_addr][1]};
    end

endmodule

/* verilog/hub75_pkg.sv */
package hub75_pkg;

    // panel geometry
    localparam int PIXEL_WIDTH       = 16;
    localparam int PIXEL_HEIGHT      = 8;
    localparam int PIXEL_HALFHEIGHT  = PIXEL_HEIGHT / 2; // rows driven per scan line pair
    localparam int BRIGHTNESS_LEVELS = 5;

    // timing
    localparam int CTRL_TICKS_PER_BIT = 4;   // clocks per uart bit
    localparam int OE_BASE_CYCLES     = 4;   // enable time of plane 0

    // command codes
    localparam logic [7:0] CMD_SET_PIXEL  = 8'hA0;
    localparam logic [7:0] CMD_BRIGHTNESS = 8'hB0;
    localparam logic [7:0] CMD_RGB_ENABLE = 8'hC0;

    typedef logic [15:0] pixel_t;   // rgb565, red in the top bits
    typedef logic [2:0]  rgb_t;     // bit 0 red, bit 1 green, bit 2 blue
    typedef logic [$clog2(BRIGHTNESS_LEVELS)-1:0] plane_t;

endpackage

/* verilog/hub75_top.sv */
`timescale 1ns/10ps
module hub75_top #(
    parameter int PIXEL_WIDTH       = hub75_pkg::PIXEL_WIDTH,
    parameter int PIXEL_HEIGHT      = hub75_pkg::PIXEL_HEIGHT,
    parameter int BRIGHTNESS_LEVELS = hub75_pkg::BRIGHTNESS_LEVELS,
    parameter int TICKS_PER_BIT     = hub75_pkg::CTRL_TICKS_PER_BIT,
    parameter int OE_BASE_CYCLES    = hub75_pkg::OE_BASE_CYCLES,
    localparam int ROW_W = $clog2(PIXEL_HEIGHT / 2)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             uart_rx_line,
    output hub75_pkg::rgb_t  rgb_top,
    output hub75_pkg::rgb_t  rgb_bottom,
    output logic             clk_pixel,
    output logic             row_latch,
    output logic             output_enable,
    output logic [ROW_W-1:0] row_addr
);
    localparam int WORD_W = $clog2(PIXEL_WIDTH * PIXEL_HEIGHT / 2);

    logic [7:0]                   rx_data;
    logic                         rx_valid;
    logic                         wr_en;
    logic [WORD_W+1:0]            wr_addr;
    logic [7:0]                   wr_data;
    logic [WORD_W-1:0]            rd_addr;
    hub75_pkg::pixel_t [1:0]      rd_data;
    logic [BRIGHTNESS_LEVELS-1:0] brightness_enable;
    hub75_pkg::rgb_t              rgb_enable;

    pixel_fetch_if #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .PIXEL_HEIGHT(PIXEL_HEIGHT)
    ) fetch_bus ();

    // command path
    uart_rx #(
        .TICKS_PER_BIT(TICKS_PER_BIT)
    ) uart_rx_inst (
        .clk(clk),
        .rst_n(rst_n),
        .rx_line(uart_rx_line),
        .rx_data(rx_data),
        .rx_valid(rx_valid)
    );

    command_decoder #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .PIXEL_HEIGHT(PIXEL_HEIGHT),
        .BRIGHTNESS_LEVELS(BRIGHTNESS_LEVELS)
    ) command_decoder_inst (
        .clk(clk),
        .rst_n(rst_n),
        .rx_data(rx_data),
        .rx_valid(rx_valid),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .brightness_enable(brightness_enable),
        .rgb_enable(rgb_enable)
    );

    framebuffer_ram #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .PIXEL_HEIGHT(PIXEL_HEIGHT)
    ) framebuffer_ram_inst (
        .clk(clk),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

    // scan path
    pixel_fetch #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .PIXEL_HEIGHT(PIXEL_HEIGHT),
        .BRIGHTNESS_LEVELS(BRIGHTNESS_LEVELS)
    ) pixel_fetch_inst (
        .clk(clk),
        .rst_n(rst_n),
        .fetch(fetch_bus.fetch),
        .rd_data(rd_data),
        .brightness_enable(brightness_enable),
        .rgb_enable(rgb_enable),
        .rd_addr(rd_addr),
        .rgb_top(rgb_top),
        .rgb_bottom(rgb_bottom)
    );

    matrix_scan #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .PIXEL_HEIGHT(PIXEL_HEIGHT),
        .BRIGHTNESS_LEVELS(BRIGHTNESS_LEVELS),
        .OE_BASE_CYCLES(OE_BASE_CYCLES)
    ) matrix_scan_inst (
        .clk(clk),
        .rst_n(rst_n),
        .fetch(fetch_bus.scan),
        .clk_pixel(clk_pixel),
        .row_latch(row_latch),
        .output_enable(output_enable),
        .row_addr(row_addr)
    );

endmodule

/* verilog/matrix_scan.sv */
`timescale 1ns/10ps
module matrix_scan #(
    parameter int PIXEL_WIDTH       = hub75_pkg::PIXEL_WIDTH,
    parameter int PIXEL_HEIGHT      = hub75_pkg::PIXEL_HEIGHT,
    parameter int BRIGHTNESS_LEVELS = hub75_pkg::BRIGHTNESS_LEVELS,
    parameter int OE_BASE_CYCLES    = hub75_pkg::OE_BASE_CYCLES,
    localparam int ROW_W = $clog2(PIXEL_HEIGHT / 2)
) (
    input  logic             clk,
    input  logic             rst_n,
    pixel_fetch_if.scan      fetch,
    output logic             clk_pixel,
    output logic             row_latch,
    output logic             output_enable,
    output logic [ROW_W-1:0] row_addr
);
    localparam int COL_W = $clog2(PIXEL_WIDTH);
    localparam int OE_W  = $clog2(OE_BASE_CYCLES << (BRIGHTNESS_LEVELS - 1));

    typedef enum logic [1:0] {SHIFT, LATCH, ENABLE} state_t;

    state_t            state;
    logic [1:0]        phase;   // four clocks per pixel
    logic [COL_W-1:0]  col;
    hub75_pkg::plane_t plane;
    logic [ROW_W-1:0]  row;
    logic [OE_W-1:0]   oe_cnt;

    assign fetch.load   = state == SHIFT && phase == 2'd0;
    assign fetch.column = col;
    assign fetch.row    = row;
    assign fetch.plane  = plane;

    assign clk_pixel     = state == SHIFT && phase == 2'd3;   // rgb stable since phase 2
    assign row_latch     = state == LATCH;
    assign output_enable = state == ENABLE;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= SHIFT;
            phase    <= '0;
            col      <= '0;
            plane    <= '0;
            row      <= '0;
            row_addr <= '0;
            oe_cnt   <= '0;
        end else begin
            case (state)
                SHIFT: begin
                    phase <= phase + 2'd1;
                    if (phase == 2'd3) begin
                        if (col == COL_W'(PIXEL_WIDTH - 1)) begin
                            col      <= '0;
                            row_addr <= row;    // visible during the latch cycle
                            state    <= LATCH;
                        end else begin
                            col <= col + 1'b1;
                        end
                    end
                end
                LATCH: begin
                    oe_cnt <= OE_W'((OE_BASE_CYCLES << plane) - 1);   // binary weighted
                    state  <= ENABLE;
                end
                default: begin
                    oe_cnt <= oe_cnt - 1'b1;
                    if (oe_cnt == '0) begin
                        state <= SHIFT;
                        if (plane == hub75_pkg::plane_t'(BRIGHTNESS_LEVELS - 1)) begin
                            plane <= '0;
                            row   <= (row == ROW_W'(PIXEL_HEIGHT / 2 - 1)) ? '0 : row + 1'b1;
                        end else begin
                            plane <= plane + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    a_latch_alone: assert property (@(posedge clk) disable iff (!rst_n)
        row_latch |-> !clk_pixel && !output_enable ##1 output_enable);

    a_load_phase: assert property (@(posedge clk) disable iff (!rst_n)
        fetch.load |-> phase == 2'd0 ##3 clk_pixel);

endmodule

/* verilog/pixel_fetch.sv */
`timescale 1ns/10ps
module pixel_fetch #(
    parameter int PIXEL_WIDTH       = hub75_pkg::PIXEL_WIDTH,
    parameter int PIXEL_HEIGHT      = hub75_pkg::PIXEL_HEIGHT,
    parameter int BRIGHTNESS_LEVELS = hub75_pkg::BRIGHTNESS_LEVELS,
    localparam int WORD_W = $clog2(PIXEL_WIDTH * PIXEL_HEIGHT / 2)
) (
    input  logic                         clk,
    input  logic                         rst_n,
    pixel_fetch_if.fetch                 fetch,
    input  hub75_pkg::pixel_t [1:0]      rd_data,
    input  logic [BRIGHTNESS_LEVELS-1:0] brightness_enable,
    input  hub75_pkg::rgb_t              rgb_enable,
    output logic [WORD_W-1:0]            rd_addr,
    output hub75_pkg::rgb_t              rgb_top,
    output hub75_pkg::rgb_t              rgb_bottom
);
    logic              load_d;  // read data valid
    hub75_pkg::plane_t plane_q;
    hub75_pkg::rgb_t   en;

    // green has one more bit, its lsb is never shown
    function automatic hub75_pkg::rgb_t plane_bits(input hub75_pkg::pixel_t px,
                                                   input hub75_pkg::plane_t p);
        hub75_pkg::rgb_t bits;
        bits[0] = px[11 + p];
        bits[1] = px[6 + p];
        bits[2] = px[p];
        return bits;
    endfunction

    assign rd_addr = WORD_W'(fetch.row * PIXEL_WIDTH + fetch.column);
    assign en      = rgb_enable & {3{brightness_enable[plane_q]}};

    always_ff @(posedge clk) begin
        if (fetch.load) plane_q <= fetch.plane;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_d     <= 1'b0;
            rgb_top    <= '0;
            rgb_bottom <= '0;
        end else begin
            load_d <= fetch.load;
            if (load_d) begin   // held until the next load
                rgb_top    <= plane_bits(rd_data[0], plane_q) & en;
                rgb_bottom <= plane_bits(rd_data[1], plane_q) & en;
            end
        end
    end

endmodule

/* verilog/pixel_fetch_if.sv */
`timescale 1ns/10ps
interface pixel_fetch_if #(
    parameter int PIXEL_WIDTH  = hub75_pkg::PIXEL_WIDTH,
    parameter int PIXEL_HEIGHT = hub75_pkg::PIXEL_HEIGHT
);
    logic                                load;   // one cycle per pixel step
    logic [$clog2(PIXEL_WIDTH)-1:0]      column;
    logic [$clog2(PIXEL_HEIGHT / 2)-1:0] row;    // scan row, top half index
    hub75_pkg::plane_t                   plane;

    modport scan (
        output load, column, row, plane
    );

    modport fetch (
        input load, column, row, plane
    );
endinterface

/* verilog/uart_rx.sv */
`timescale 1ns/10ps
module uart_rx #(
    parameter int TICKS_PER_BIT = hub75_pkg::CTRL_TICKS_PER_BIT
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx_line,
    output logic [7:0] rx_data,
    output logic       rx_valid
);
    localparam int TW = $clog2(TICKS_PER_BIT);
    localparam logic [TW-1:0] HALF_TICK = TW'(TICKS_PER_BIT / 2 - 1);
    localparam logic [TW-1:0] LAST_TICK = TW'(TICKS_PER_BIT - 1);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_t;

    state_t        state;
    logic [1:0]    sync;
    logic          rx_prev;
    logic [TW-1:0] tick_cnt;
    logic [2:0]    bit_idx;
    logic [7:0]    shift;

    wire rx_s = sync[1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync     <= 2'b11;  // line idles high
            rx_prev  <= 1'b1;
            state    <= IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            sync     <= {sync[0], rx_line};
            rx_prev  <= rx_s;
            rx_valid <= 1'b0;
            tick_cnt <= tick_cnt + 1'b1;
            case (state)
                IDLE: begin
                    tick_cnt <= '0;
                    if (rx_prev && !rx_s) state <= START;   // falling edge
                end
                START: begin
                    if (tick_cnt == HALF_TICK) begin
                        tick_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= rx_s ? IDLE : DATA;     // glitch goes back
                    end
                end
                DATA: begin
                    if (tick_cnt == LAST_TICK) begin
                        tick_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= STOP;
                    end
                end
                default: begin
                    if (tick_cnt == LAST_TICK) begin
                        rx_valid <= rx_s;   // framing error drops the byte
                        state    <= IDLE;
                    end
                end
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk) begin
        if (state == DATA && tick_cnt == LAST_TICK) shift <= {rx_s, shift[7:1]};
        if (state == STOP && tick_cnt == LAST_TICK) rx_data <= shift;
    end

    a_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        rx_valid |=> !rx_valid);

endmodule
